//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = ram2_tb
FILE_LIST = files.f
BUILD_DIR = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

//--- files.f
+incdir+source
source/ram2_pkg.sv
source/ram2_req_arbiter.sv
source/ram2_bus_sequencer.sv
source/ram2_result_router.sv
source/ram2_port.sv
tb/tb_clock.sv
tb/sram_model.sv
tb/ram2_props.sv
tb/ram2_tb.sv

//--- source/ram2_bus_sequencer.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module ram2_bus_sequencer (
	input  logic                     clk,
	input  logic                     rst,
	input  ram2_pkg::ram2_req_t      req,
	input  logic                     req_valid,
	output logic                     busy,
	output ram2_pkg::ram2_rsp_t      rsp,
	output logic                     rsp_valid,
	output logic [`RAM2_ADDR_W-1:0]  ram2_addr,
	inout  wire  [`RAM2_DATA_W-1:0]  ram2_data,
	output logic                     ram2_en,
	output logic                     ram2_oe,
	output logic                     ram2_we
);

	logic [`RAM2_DIV_W-1:0]  div;
	logic                    tick;
	logic                    last_phase;
	logic                    drive;
	ram2_pkg::ram2_state_e   state;
	ram2_pkg::ram2_state_e   state_next;
	ram2_pkg::ram2_req_t     cur;

	////////////////////////////////////////////////////////////
	// Divider and request latch
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			div <= '0;
		end else begin
			div <= div + 1'b1;
		end
	end

	assign tick = (div == '0);

	always_ff @(posedge clk) begin
		if (req_valid) begin
			cur <= req;
		end
	end

	////////////////////////////////////////////////////////////
	// Phase machine
	////////////////////////////////////////////////////////////

	assign last_phase = (state == ram2_pkg::ST_EXE_RD3) ||
			(state == ram2_pkg::ST_IF_RD3) ||
			(state == ram2_pkg::ST_WR3);

	always_comb begin
		state_next = ram2_pkg::ST_IDLE;
		case (state)
			ram2_pkg::ST_IDLE: begin
				if (busy) begin
					case (cur.op)
						ram2_pkg::OP_EXE_RD: state_next = ram2_pkg::ST_EXE_RD1;
						ram2_pkg::OP_EXE_WR: state_next = ram2_pkg::ST_WR1;
						default:             state_next = ram2_pkg::ST_IF_RD1;
					endcase
				end
			end
			ram2_pkg::ST_EXE_RD1: state_next = ram2_pkg::ST_EXE_RD2;
			ram2_pkg::ST_EXE_RD2: state_next = ram2_pkg::ST_EXE_RD3;
			ram2_pkg::ST_IF_RD1:  state_next = ram2_pkg::ST_IF_RD2;
			ram2_pkg::ST_IF_RD2:  state_next = ram2_pkg::ST_IF_RD3;
			ram2_pkg::ST_WR1:     state_next = ram2_pkg::ST_WR2;
			ram2_pkg::ST_WR2:     state_next = ram2_pkg::ST_WR3;
			default:              state_next = ram2_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= ram2_pkg::ST_IDLE;
			busy <= 1'b0;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= tick && last_phase;
			if (req_valid) begin
				busy <= 1'b1;
			end else if (rsp_valid) begin
				busy <= 1'b0;
			end
			if (tick) begin
				state <= state_next;
			end
		end
	end

	// Sample at the end of the third phase
	always_ff @(posedge clk) begin
		if (tick && last_phase) begin
			rsp.op <= cur.op;
			rsp.act <= cur.act;
			if (cur.op != ram2_pkg::OP_EXE_WR) begin
				rsp.rdata <= ram2_data;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////////////////////////

	always_comb begin
		ram2_en = 1'b1;
		ram2_oe = 1'b1;
		ram2_we = 1'b1;
		drive = 1'b0;
		case (state)
			ram2_pkg::ST_EXE_RD1, ram2_pkg::ST_EXE_RD2, ram2_pkg::ST_EXE_RD3,
			ram2_pkg::ST_IF_RD1, ram2_pkg::ST_IF_RD2, ram2_pkg::ST_IF_RD3: begin
				ram2_en = 1'b0;
				ram2_oe = 1'b0;
			end
			ram2_pkg::ST_WR1, ram2_pkg::ST_WR3: begin
				ram2_en = 1'b0;
				drive = 1'b1;
			end
			ram2_pkg::ST_WR2: begin
				ram2_en = 1'b0;
				ram2_we = 1'b0;
				drive = 1'b1;
			end
			default: begin
				drive = 1'b0;
			end
		endcase
	end

	// Data stays on the bus one phase past the write strobe
	assign ram2_data = drive ? cur.wdata : 'z;
	assign ram2_addr = cur.addr;

endmodule

//--- source/ram2_config.svh
`ifndef RAM2_CONFIG_SVH
`define RAM2_CONFIG_SVH

////////////////////////////////////////////////////////////
// SRAM geometry
////////////////////////////////////////////////////////////

`define RAM2_ADDR_W 18
`define RAM2_DATA_W 16

////////////////////////////////////////////////////////////
// Bus pacing
////////////////////////////////////////////////////////////

// One phase step every 2**RAM2_DIV_W clocks
`define RAM2_DIV_W 2

`endif

//--- source/ram2_pkg.sv
`include "ram2_config.svh"

package ram2_pkg;

	typedef enum logic [1:0] {
		OP_IF_RD  = 2'd0,
		OP_EXE_RD = 2'd1,
		OP_EXE_WR = 2'd2
	} ram2_op_e;

	// Fetch read phases follow the execute read phases
	typedef enum logic [3:0] {
		ST_IDLE    = 4'd0,
		ST_EXE_RD1 = 4'd1,
		ST_EXE_RD2 = 4'd2,
		ST_EXE_RD3 = 4'd3,
		ST_IF_RD1  = 4'd4,
		ST_IF_RD2  = 4'd5,
		ST_IF_RD3  = 4'd6,
		ST_WR1     = 4'd7,
		ST_WR2     = 4'd8,
		ST_WR3     = 4'd9
	} ram2_state_e;

	// 2 + 18 + 16 + 32 = 68 bits
	typedef struct packed {
		ram2_op_e                  op;
		logic [`RAM2_ADDR_W-1:0]   addr;
		logic [`RAM2_DATA_W-1:0]   wdata;
		logic [31:0]               act;
	} ram2_req_t;

	// 2 + 16 + 32 = 50 bits
	typedef struct packed {
		ram2_op_e                  op;
		logic [`RAM2_DATA_W-1:0]   rdata;
		logic [31:0]               act;
	} ram2_rsp_t;

endpackage

//--- source/ram2_port.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module ram2_port (
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     if_need,
	input  logic                     exe_need,
	input  logic                     exe_rd,
	input  logic                     exe_wr,
	input  logic [31:0]              act,
	input  logic [`RAM2_ADDR_W-1:0]  if_addr,
	input  logic [`RAM2_ADDR_W-1:0]  exe_addr,
	input  logic [`RAM2_DATA_W-1:0]  exe_wdata,

	output logic [`RAM2_ADDR_W-1:0]  ram2_addr,
	inout  wire  [`RAM2_DATA_W-1:0]  ram2_data,
	output logic                     ram2_en,
	output logic                     ram2_oe,
	output logic                     ram2_we,

	output logic [`RAM2_DATA_W-1:0]  if_result,
	output logic [`RAM2_DATA_W-1:0]  exe_result,
	output logic                     if_done,
	output logic                     exe_done,
	output logic [31:0]              act_done
);

	ram2_pkg::ram2_req_t  req;
	ram2_pkg::ram2_rsp_t  rsp;
	logic                 req_valid;
	logic                 rsp_valid;
	logic                 busy;
	logic                 if_start;
	logic                 exe_start;

	ram2_req_arbiter i_req_arbiter (
		.clk       (clk),
		.rst       (rst),
		.if_need   (if_need),
		.exe_need  (exe_need),
		.exe_rd    (exe_rd),
		.exe_wr    (exe_wr),
		.act       (act),
		.if_addr   (if_addr),
		.exe_addr  (exe_addr),
		.exe_wdata (exe_wdata),
		.busy      (busy),
		.req       (req),
		.req_valid (req_valid),
		.if_start  (if_start),
		.exe_start (exe_start)
	);

	ram2_bus_sequencer i_bus_sequencer (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.req_valid (req_valid),
		.busy      (busy),
		.rsp       (rsp),
		.rsp_valid (rsp_valid),
		.ram2_addr (ram2_addr),
		.ram2_data (ram2_data),
		.ram2_en   (ram2_en),
		.ram2_oe   (ram2_oe),
		.ram2_we   (ram2_we)
	);

	ram2_result_router i_result_router (
		.clk        (clk),
		.rst        (rst),
		.rsp        (rsp),
		.rsp_valid  (rsp_valid),
		.if_start   (if_start),
		.exe_start  (exe_start),
		.if_result  (if_result),
		.exe_result (exe_result),
		.if_done    (if_done),
		.exe_done   (exe_done),
		.act_done   (act_done)
	);

endmodule

//--- source/ram2_req_arbiter.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module ram2_req_arbiter (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     if_need,
	input  logic                     exe_need,
	input  logic                     exe_rd,
	input  logic                     exe_wr,
	input  logic [31:0]              act,
	input  logic [`RAM2_ADDR_W-1:0]  if_addr,
	input  logic [`RAM2_ADDR_W-1:0]  exe_addr,
	input  logic [`RAM2_DATA_W-1:0]  exe_wdata,
	input  logic                     busy,
	output ram2_pkg::ram2_req_t      req,
	output logic                     req_valid,
	output logic                     if_start,
	output logic                     exe_start
);

	logic                 exe_want;
	logic                 fresh;
	logic                 take;
	logic                 slot_full;
	logic [31:0]          last_act;
	ram2_pkg::ram2_req_t  slot;
	ram2_pkg::ram2_req_t  incoming;

	// Execute side only counts with a real operation
	assign exe_want = exe_need && (exe_rd || exe_wr);

	// Same token as last time means the requester is just holding its level
	assign fresh = (exe_want || if_need) && (act != last_act);
	assign take = fresh && !slot_full;

	assign exe_start = take && exe_want;
	assign if_start = take && !exe_want;

	always_comb begin
		if (exe_want) begin
			// read wins if both bits are set
			incoming.op = exe_rd ? ram2_pkg::OP_EXE_RD : ram2_pkg::OP_EXE_WR;
			incoming.addr = exe_addr;
			incoming.wdata = exe_wdata;
		end else begin
			incoming.op = ram2_pkg::OP_IF_RD;
			incoming.addr = if_addr;
			incoming.wdata = '0;
		end
		incoming.act = act;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			slot_full <= 1'b0;
			last_act <= '0;
		end else begin
			if (take) begin
				slot_full <= 1'b1;
				last_act <= act;
			end else if (req_valid) begin
				slot_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			slot <= incoming;
		end
	end

	// Offer the slot only while the sequencer is free
	assign req = slot;
	assign req_valid = slot_full && !busy;

endmodule

//--- source/ram2_result_router.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module ram2_result_router (
	input  logic                     clk,
	input  logic                     rst,
	input  ram2_pkg::ram2_rsp_t      rsp,
	input  logic                     rsp_valid,
	input  logic                     if_start,
	input  logic                     exe_start,
	output logic [`RAM2_DATA_W-1:0]  if_result,
	output logic [`RAM2_DATA_W-1:0]  exe_result,
	output logic                     if_done,
	output logic                     exe_done,
	output logic [31:0]              act_done
);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			if_result <= '0;
			exe_result <= '0;
			if_done <= 1'b0;
			exe_done <= 1'b0;
			act_done <= '0;
		end else begin
			// New request on a side drops its done level
			if (if_start) begin
				if_done <= 1'b0;
			end
			if (exe_start) begin
				exe_done <= 1'b0;
			end

			if (rsp_valid) begin
				act_done <= rsp.act;
				case (rsp.op)
					ram2_pkg::OP_IF_RD: begin
						if_result <= rsp.rdata;
						if_done <= 1'b1;
					end
					ram2_pkg::OP_EXE_RD: begin
						exe_result <= rsp.rdata;
						exe_done <= 1'b1;
					end
					// write has no data to return
					default: begin
						exe_done <= 1'b1;
					end
				endcase
			end
		end
	end

endmodule

//--- tb/ram2_cases.txt
// Columns: kind address write_data expected, all hex
// kind 0 fetch read, 1 execute read, 2 execute write, 3 both sides read, 4 repeat token
0 00010 0000 5a4a
1 00123 0000 5b79
0 3ffff 0000 a5a6
1 20000 0000 5a58
2 00200 beef 0000
1 00200 0000 beef
0 00200 0000 beef
2 1abcd 1234 0000
0 1abcd 0000 1234
1 1abcd 0000 1234
3 00200 0000 beef
3 00300 0000 595a
4 00300 0000 0000
2 00300 c0de 0000
3 00300 0000 c0de
4 00300 0000 0000

//--- tb/ram2_props.sv
`timescale 1ns/1ps

module ram2_props (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ram2_en,
	input  logic                   ram2_oe,
	input  logic                   ram2_we,
	input  logic                   rsp_valid,
	input  logic                   busy,
	input  ram2_pkg::ram2_state_e  state
);

	int failures = 0;

	we_in_write: assert property (@(posedge clk) disable iff (!rst)
			!ram2_we |-> (!ram2_en && ram2_oe))
		else begin
			failures++;
			$error("write strobe outside an enabled write cycle");
		end

	oe_we_apart: assert property (@(posedge clk) disable iff (!rst)
			!(!ram2_oe && !ram2_we))
		else begin
			failures++;
			$error("output enable and write enable low together");
		end

	rsp_single: assert property (@(posedge clk) disable iff (!rst)
			rsp_valid |=> !rsp_valid)
		else begin
			failures++;
			$error("response strobe held for two cycles");
		end

	// A bus phase only runs for an accepted request
	phase_busy: assert property (@(posedge clk) disable iff (!rst)
			(state != ram2_pkg::ST_IDLE) |-> busy)
		else begin
			failures++;
			$error("sequencer in a bus phase while not busy");
		end

endmodule

bind ram2_bus_sequencer ram2_props i_ram2_props (.*);

//--- tb/ram2_tb.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module ram2_tb;

	localparam int max_cases = 64;
	localparam int rand_pairs = 8;
	localparam int cycle_ns = 40;

	logic                     clk, rst;
	logic                     if_need, exe_need, exe_rd, exe_wr;
	logic [31:0]              act, act_done;
	logic [`RAM2_ADDR_W-1:0]  if_addr, exe_addr, ram2_addr;
	logic [`RAM2_DATA_W-1:0]  exe_wdata, if_result, exe_result;
	logic                     ram2_en, ram2_oe, ram2_we, if_done, exe_done;
	// Pulled up so a released bus reads as all ones
	tri1  [`RAM2_DATA_W-1:0]  ram2_data;

	logic [31:0]              case_mem [0:4*max_cases-1];
	logic [`RAM2_DATA_W-1:0]  shadow [logic [`RAM2_ADDR_W-1:0]];
	int                       num_cases;
	int                       errors;
	int                       checks;
	integer                   seed;
	bit                       loaded;

	tb_clock #(.period(cycle_ns)) i_tb_clock (
		.clk (clk),
		.rst (rst)
	);

	ram2_port i_ram2_port (.*);

	sram_model i_sram_model (
		.addr (ram2_addr),
		.data (ram2_data),
		.en   (ram2_en),
		.oe   (ram2_oe),
		.we   (ram2_we)
	);

	function automatic logic [`RAM2_DATA_W-1:0] expected_at(
			input logic [`RAM2_ADDR_W-1:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		// Unwritten cells hold the address pattern
		return addr[15:0] ^ 16'(addr >> 16) ^ 16'h5a5a;
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	task automatic drop_needs();
		if_need = 1'b0;
		exe_need = 1'b0;
		exe_rd = 1'b0;
		exe_wr = 1'b0;
	endtask

	// kind 0 fetch read, 1 execute read, 2 execute write, 3 both sides read
	task automatic run_request(input int kind, input logic [`RAM2_ADDR_W-1:0] addr,
			input logic [`RAM2_DATA_W-1:0] wdata, input logic [`RAM2_DATA_W-1:0] expected);
		logic [31:0] token;
		@(negedge clk);
		token = act + 32'd1;
		act = token;
		if (kind == 0 || kind == 3) begin
			if_need = 1'b1;
			if_addr = addr;
		end
		if (kind != 0) begin
			exe_need = 1'b1;
			exe_rd = (kind != 2);
			exe_wr = (kind == 2);
			exe_addr = addr;
			exe_wdata = wdata;
		end
		@(negedge clk);
		if (kind == 3) begin
			// Execute sits in the slot, fetch gets a token of its own
			exe_need = 1'b0;
			token = token + 32'd1;
			act = token;
		end
		if (kind != 0) begin
			while (!exe_done) begin
				@(negedge clk);
			end
			checks++;
			if (kind == 2) begin
				shadow[addr] = wdata;
			end else if (exe_result !== expected) begin
				report_fail($sformatf("exe_result %h at %h, expected %h",
						exe_result, addr, expected));
			end
			if (kind == 3 && if_done) begin
				report_fail("if_done rose before exe_done");
			end
		end
		if (kind == 0 || kind == 3) begin
			while (!if_done) begin
				@(negedge clk);
			end
			checks++;
			if (if_result !== expected) begin
				report_fail($sformatf("if_result %h at %h, expected %h",
						if_result, addr, expected));
			end
		end
		if (act_done !== token) begin
			report_fail($sformatf("act_done %h, expected %h", act_done, token));
		end
		drop_needs();
	endtask

	// Same token again must not start a bus cycle
	task automatic hold_check();
		@(negedge clk);
		if_need = 1'b1;
		exe_need = 1'b1;
		exe_rd = 1'b1;
		repeat (50) begin
			@(negedge clk);
			checks++;
			if (!ram2_en) begin
				report_fail("ram2_en went low for a repeated token");
			end
			if (!exe_done || !if_done) begin
				report_fail("done level dropped for a repeated token");
			end
		end
		drop_needs();
	endtask

	initial begin
		logic [31:0]              rnd;
		logic [`RAM2_ADDR_W-1:0]  r_addr;
		logic [`RAM2_DATA_W-1:0]  r_data;
		drop_needs();
		act = '0;
		if_addr = '0;
		exe_addr = '0;
		exe_wdata = '0;
		errors = 0;
		checks = 0;
		seed = 32'hb618_0bd2;
		for (int i = 0; i < 4 * max_cases; i++) begin
			case_mem[i] = 32'hffff_ffff;
		end
		$readmemh("tb/ram2_cases.txt", case_mem);
		num_cases = 0;
		while (num_cases < max_cases && case_mem[4 * num_cases] != 32'hffff_ffff) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			report_fail("no cases read from tb/ram2_cases.txt");
		end
		loaded = 1'b1;

		@(negedge clk);
		checks++;
		if (ram2_en !== 1'b1 || ram2_oe !== 1'b1 || ram2_we !== 1'b1) begin
			report_fail("SRAM controls not high during reset");
		end
		if (ram2_data !== 16'hffff) begin
			report_fail($sformatf("data bus %h not released during reset", ram2_data));
		end
		if (if_done !== 1'b0 || exe_done !== 1'b0 || act_done !== '0) begin
			report_fail("done levels or act_done not cleared by reset");
		end
		wait (rst === 1'b1);
		@(posedge clk);

		for (int i = 0; i < num_cases; i++) begin
			if (case_mem[4 * i] == 32'd4) begin
				hold_check();
			end else begin
				run_request(int'(case_mem[4 * i]), case_mem[4 * i + 1][`RAM2_ADDR_W-1:0],
						case_mem[4 * i + 2][`RAM2_DATA_W-1:0],
						case_mem[4 * i + 3][`RAM2_DATA_W-1:0]);
			end
		end

		// Random write then read back, alternating fetch and execute reads
		for (int i = 0; i < rand_pairs; i++) begin
			rnd = $random(seed);
			r_addr = rnd[`RAM2_ADDR_W-1:0];
			rnd = $random(seed);
			r_data = rnd[`RAM2_DATA_W-1:0];
			run_request(2, r_addr, r_data, 16'h0000);
			run_request(i % 2, r_addr, 16'h0000, expected_at(r_addr));
		end

		if (i_ram2_port.i_bus_sequencer.i_ram2_props.failures != 0) begin
			errors += i_ram2_port.i_bus_sequencer.i_ram2_props.failures;
			$display("SRAM protocol assertions failed during the run");
		end
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#((num_cases + 2 * rand_pairs + 4) * 200 * cycle_ns);
		$display("Timeout: a request never raised its done level");
		$display("sim failed");
		$finish;
	end

endmodule

//--- tb/sram_model.sv
`timescale 1ns/1ps
`include "ram2_config.svh"

module sram_model (
	input  logic [`RAM2_ADDR_W-1:0]  addr,
	inout  wire  [`RAM2_DATA_W-1:0]  data,
	input  logic                     en,
	input  logic                     oe,
	input  logic                     we
);

	logic [`RAM2_DATA_W-1:0] mem [0:(1 << `RAM2_ADDR_W)-1];

	// Low address bits XOR 5a5a, top address bits folded in above 64K
	initial begin
		logic [`RAM2_ADDR_W-1:0] a;
		for (int i = 0; i < (1 << `RAM2_ADDR_W); i++) begin
			a = i[`RAM2_ADDR_W-1:0];
			mem[a] = a[15:0] ^ 16'(a >> 16) ^ 16'h5a5a;
		end
	end

	// Cell takes the data at the end of the write strobe
	always @(posedge we) begin
		if (!en) begin
			mem[addr] <= data;
		end
	end

	assign data = (!en && !oe && we) ? mem[addr] : 'z;

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 40
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Two rising edges inside reset, released on a falling edge
	initial begin
		rst = 1'b0;
		#(period * 2) rst = 1'b1;
	end

endmodule
